/* axi_sram_top.f */
+incdir+.
axi_pkg.sv
mem_pkg.sv
sram_mem.sv
axi_rd_ctrl.sv
axi_wr_ctrl.sv
axi_sram_top.sv
tb_axi_sram_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_axi_sram_top
FILELIST  := axi_sram_top.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for a pass"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb_axi_sram_top.sv */
// AXI SRAM testbench
`default_nettype none

`include "axi_sram_params.svh"

module tb_axi_sram_top;
  import axi_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_OPS    = 300;
  localparam int POOL_SIZE  = 16;
  // About 300 operations at up to 20 cycles each, plus margin
  localparam int MAX_CYCLES = 8000;

  logic     i_aclk;
  logic     i_arst_n;
  axi_aw_t  aw;
  logic     awvalid;
  logic     awready;
  axi_w_t   w;
  logic     wvalid;
  logic     wready;
  axi_b_t   b;
  logic     bvalid;
  logic     bready;
  axi_ar_t  ar;
  logic     arvalid;
  logic     arready;
  axi_r_t   r;
  logic     rvalid;
  logic     rready;

  integer    seed = 41826;
  int        errors = 0;
  int        checks = 0;
  int        cycles = 0;
  logic [63:0] shadow [int];
  axi_r_t    exp_r_q [$];
  axi_aw_t   wr_aw;
  axi_w_t    wr_w;

  axi_sram_top dut (
    .i_aclk    (i_aclk),    .i_arst_n  (i_arst_n),
    .i_aw      (aw),        .i_awvalid (awvalid),   .o_awready (awready),
    .i_w       (w),         .i_wvalid  (wvalid),    .o_wready  (wready),
    .o_b       (b),         .o_bvalid  (bvalid),    .i_bready  (bready),
    .i_ar      (ar),        .i_arvalid (arvalid),   .o_arready (arready),
    .o_r       (r),         .o_rvalid  (rvalid),    .i_rready  (rready)
  );

  initial begin
    i_aclk = 1'b0;
    forever #(CLK_PERIOD / 2) i_aclk = ~i_aclk;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic logic in_range(input axi_addr_t addr);
    return addr[`AXI_ADDR_W-1:13] == '0;
  endfunction

  function automatic axi_resp_e ref_write_resp(input axi_addr_t addr);
    return in_range(addr) ? OKAY : DECERR;
  endfunction

  // Expected read beat, ID filled in by the caller
  function automatic axi_r_t ref_read(input axi_addr_t addr);
    axi_r_t exp;
    exp.id   = '0;
    exp.last = 1'b1;
    exp.resp = ref_write_resp(addr);
    if (exp.resp == OKAY && shadow.exists(int'(addr[12:3]))) begin
      exp.data = shadow[int'(addr[12:3])];
    end else if (exp.resp == OKAY) begin
      exp.data = 'x;
    end else begin
      exp.data = '0;
    end
    return exp;
  endfunction

  task automatic check_val(input string what, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // Comparing process
  // ----------------------------------------

  always @(posedge i_aclk) begin
    axi_r_t exp;
    int idx;
    if (i_arst_n) begin
      if (rvalid && rready) begin
        if (exp_r_q.size() == 0) begin
          errors++;
          $display("Read data arrived with no read outstanding at %0t", $time);
        end else begin
          exp = exp_r_q.pop_front();
          check_val("R id", r.id, exp.id);
          check_val("R data", r.data, exp.data);
          check_val("R resp", r.resp, exp.resp);
          check_val("R last", r.last, 1'b1);
        end
      end
      if (bvalid && bready) begin
        check_val("B id", b.id, wr_aw.id);
        check_val("B resp", b.resp, ref_write_resp(wr_aw.addr));
        if (ref_write_resp(wr_aw.addr) == OKAY) begin
          idx = int'(wr_aw.addr[12:3]);
          if (!shadow.exists(idx)) shadow[idx] = 'x;
          for (int k = 0; k < 8; k++) begin
            if (wr_w.strb[k]) shadow[idx][8*k +: 8] = wr_w.data[8*k +: 8];
          end
        end
      end
    end
  end

  always @(posedge i_aclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ----------------------------------------
  // Bus tasks
  // ----------------------------------------

  task automatic send_aw(input int delay);
    repeat (delay) @(posedge i_aclk);
    #1;
    aw = wr_aw;
    awvalid = 1'b1;
    @(posedge i_aclk);
    while (!awready) begin
      check_val("bvalid early", bvalid, 1'b0);
      @(posedge i_aclk);
    end
    check_val("bvalid early", bvalid, 1'b0);
    #1 awvalid = 1'b0;
  endtask

  task automatic send_w(input int delay);
    repeat (delay) @(posedge i_aclk);
    #1;
    w = wr_w;
    wvalid = 1'b1;
    @(posedge i_aclk);
    while (!wready) begin
      check_val("bvalid early", bvalid, 1'b0);
      @(posedge i_aclk);
    end
    check_val("bvalid early", bvalid, 1'b0);
    #1 wvalid = 1'b0;
  endtask

  task automatic do_write(input axi_addr_t addr, input axi_id_t id,
                          input logic [63:0] data, input axi_strb_t strb,
                          input int aw_delay, input int w_delay, input int b_stall);
    axi_b_t held;
    wr_aw = '{id: id, addr: addr};
    wr_w  = '{data: data, strb: strb};
    fork
      send_aw(aw_delay);
      send_w(w_delay);
    join
    // One cycle after the later phase
    @(posedge i_aclk);
    check_val("bvalid timing", bvalid, 1'b1);
    held = b;
    repeat (b_stall) begin
      @(posedge i_aclk);
      check_val("bvalid hold", bvalid, 1'b1);
      check_val("B hold", b, held);
    end
    #1 bready = 1'b1;
    @(posedge i_aclk);
    #1 bready = 1'b0;
    @(posedge i_aclk);
    check_val("awready after B", awready, 1'b1);
    check_val("wready after B", wready, 1'b1);
  endtask

  task automatic do_read(input axi_addr_t addr, input axi_id_t id,
                         input int ar_delay, input int r_stall);
    axi_r_t exp;
    axi_r_t held;
    exp = ref_read(addr);
    exp.id = id;
    exp_r_q.push_back(exp);
    repeat (ar_delay) @(posedge i_aclk);
    #1;
    ar = '{id: id, addr: addr};
    arvalid = 1'b1;
    @(posedge i_aclk);
    while (!arready) @(posedge i_aclk);
    check_val("rvalid early", rvalid, 1'b0);
    #1 arvalid = 1'b0;
    @(posedge i_aclk);
    check_val("rvalid timing", rvalid, 1'b1);
    check_val("arready pending", arready, 1'b0);
    held = r;
    repeat (r_stall) begin
      @(posedge i_aclk);
      check_val("rvalid hold", rvalid, 1'b1);
      check_val("arready pending", arready, 1'b0);
      check_val("R hold data", r.data, held.data);
      check_val("R hold id", r.id, held.id);
      check_val("R hold resp", r.resp, held.resp);
      check_val("R hold last", r.last, held.last);
    end
    #1 rready = 1'b1;
    @(posedge i_aclk);
    #1 rready = 1'b0;
    @(posedge i_aclk);
    check_val("arready after R", arready, 1'b1);
  endtask

  // Pool words are spread over the whole index range
  function automatic axi_addr_t pool_addr(input int k);
    return axi_addr_t'(k * 512);
  endfunction

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    axi_addr_t addr;
    i_arst_n = 1'b0;
    aw = '0;
    w = '0;
    ar = '0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    arvalid = 1'b0;
    bready = 1'b0;
    rready = 1'b0;
    repeat (5) @(posedge i_aclk);
    #1 i_arst_n = 1'b1;
    @(posedge i_aclk);
    check_val("arready reset", arready, 1'b1);
    check_val("awready reset", awready, 1'b1);
    check_val("wready reset", wready, 1'b1);
    check_val("rvalid reset", rvalid, 1'b0);
    check_val("bvalid reset", bvalid, 1'b0);

    // Known contents for every pool word
    for (int k = 0; k < POOL_SIZE; k++) begin
      do_write(pool_addr(k), 4'(k), {$random(seed), $random(seed)}, 8'hFF, 0, 0, 0);
    end
    do_read(pool_addr(3), 4'h7, 0, 0);

    // Byte merge
    do_write(pool_addr(5), 4'h1, 64'h1111_1111_1111_1111, 8'hFF, 0, 0, 0);
    do_write(pool_addr(5), 4'h2, 64'hAAAA_AAAA_AAAA_AAAA, 8'b0101_0010, 0, 0, 1);
    do_read(pool_addr(5), 4'h3, 0, 0);

    // Address first, data first, same cycle
    do_write(pool_addr(6), 4'h4, 64'h0123_4567_89AB_CDEF, 8'hFF, 0, 3, 0);
    do_read(pool_addr(6), 4'h4, 0, 0);
    do_write(pool_addr(7), 4'h5, 64'hFEDC_BA98_7654_3210, 8'hFF, 3, 0, 0);
    do_read(pool_addr(7), 4'h5, 0, 0);
    do_write(pool_addr(8), 4'h6, 64'h5A5A_0F0F_A5A5_F0F0, 8'hFF, 0, 0, 4);
    do_read(pool_addr(8), 4'h6, 2, 5);

    // Out of range write wraps onto pool word 9 if decoded wrongly
    do_write(32'h0000_2000 | pool_addr(9), 4'h9, 64'hDEAD_BEEF_DEAD_BEEF, 8'hFF, 1, 0, 2);
    do_read(pool_addr(9), 4'hA, 0, 0);
    do_read(32'h8000_0000 | pool_addr(9), 4'hB, 0, 3);

    for (int n = 0; n < NUM_OPS; n++) begin
      addr = pool_addr(($random(seed) & 32'h7FFF_FFFF) % POOL_SIZE);
      if (($random(seed) & 7) == 0) begin
        addr = addr | 32'h0000_2000 | ($random(seed) & 32'hFFFF_E000);
      end
      if ($random(seed) & 1) begin
        do_write(addr, 4'($random(seed)), {$random(seed), $random(seed)},
                 8'($random(seed)), $random(seed) & 3, $random(seed) & 3,
                 $random(seed) & 3);
      end else begin
        do_read(addr, 4'($random(seed)), $random(seed) & 3, $random(seed) & 3);
      end
    end

    repeat (3) @(posedge i_aclk);
    if (exp_r_q.size() != 0) begin
      errors++;
      $display("Read responses missing: %0d still expected", exp_r_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* axi_sram_top.sv */
// AXI4 SRAM slave top level
`default_nettype none

module axi_sram_top (
  input  logic             i_aclk,
  input  logic             i_arst_n,

  // Write address channel
  input  axi_pkg::axi_aw_t i_aw,
  input  logic             i_awvalid,
  output logic             o_awready,

  // Write data channel
  input  axi_pkg::axi_w_t  i_w,
  input  logic             i_wvalid,
  output logic             o_wready,

  // Write response channel
  output axi_pkg::axi_b_t  o_b,
  output logic             o_bvalid,
  input  logic             i_bready,

  // Read address channel
  input  axi_pkg::axi_ar_t i_ar,
  input  logic             i_arvalid,
  output logic             o_arready,

  // Read data channel
  output axi_pkg::axi_r_t  o_r,
  output logic             o_rvalid,
  input  logic             i_rready
);
  import mem_pkg::*;

  // ----------------------------------------
  // SRAM ports
  // ----------------------------------------

  mem_rd_req_t rd_req;
  mem_word_t   rd_word;
  mem_wr_req_t wr_req;

  // Read path
  axi_rd_ctrl u_rd_ctrl (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_ar      (i_ar),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_r       (o_r),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rd_req  (rd_req),
    .i_rd_word (rd_word)
  );

  // Write path, runs alongside the read path
  axi_wr_ctrl u_wr_ctrl (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_aw      (i_aw),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_w       (i_w),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_b       (o_b),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_wr_req  (wr_req)
  );

  sram_mem u_sram (
    .i_aclk    (i_aclk),
    .i_rd_req  (rd_req),
    .i_wr_req  (wr_req),
    .o_rd_word (rd_word)
  );

endmodule

`default_nettype wire

/* axi_wr_ctrl.sv */
// AXI write channel controller
`default_nettype none

`include "axi_sram_params.svh"

module axi_wr_ctrl (
  input  logic                 i_aclk,
  input  logic                 i_arst_n,
  input  axi_pkg::axi_aw_t     i_aw,
  input  logic                 i_awvalid,
  output logic                 o_awready,
  input  axi_pkg::axi_w_t      i_w,
  input  logic                 i_wvalid,
  output logic                 o_wready,
  output axi_pkg::axi_b_t      o_b,
  output logic                 o_bvalid,
  input  logic                 i_bready,
  output mem_pkg::mem_wr_req_t o_wr_req
);
  import axi_pkg::*;
  import mem_pkg::*;

  localparam int OFFS_W = $clog2(`AXI_STRB_W);
  localparam int HI_LSB = OFFS_W + `MEM_IDX_W;

  typedef enum logic {
    COLLECT,
    RESP
  } wr_state_e;

  wr_state_e state_q;
  logic      aw_have_q;
  logic      w_have_q;
  logic      wr_go_q;
  axi_aw_t   aw_q;
  axi_w_t    w_q;
  logic      aw_fire;
  logic      w_fire;
  logic      b_fire;
  logic      aw_done;
  logic      w_done;
  logic      in_range;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = i_bready & o_bvalid;

  // Phase complete, either earlier or on this edge
  assign aw_done = aw_have_q | aw_fire;
  assign w_done  = w_have_q | w_fire;

  // ----------------------------------------
  // Address/data join and response FSM
  // ----------------------------------------

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= COLLECT;
      aw_have_q <= 1'b0;
      w_have_q  <= 1'b0;
      wr_go_q   <= 1'b0;
    end else begin
      // Write strobe lasts exactly one cycle
      wr_go_q <= 1'b0;
      case (state_q)
        COLLECT: begin
          if (aw_done && w_done) begin
            state_q   <= RESP;
            aw_have_q <= 1'b0;
            w_have_q  <= 1'b0;
            wr_go_q   <= 1'b1;
          end else begin
            aw_have_q <= aw_done;
            w_have_q  <= w_done;
          end
        end
        RESP: begin
          if (b_fire) begin
            state_q <= COLLECT;
          end
        end
        default: state_q <= COLLECT;
      endcase
    end
  end

  // Captured payloads
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      aw_q <= i_aw;
    end
    if (w_fire) begin
      w_q <= i_w;
    end
  end

  // Each ready drops once its own phase is captured
  assign o_awready = (state_q == COLLECT) & ~aw_have_q;
  assign o_wready  = (state_q == COLLECT) & ~w_have_q;

  assign in_range = (aw_q.addr[`AXI_ADDR_W-1:HI_LSB] == '0);

  // ----------------------------------------
  // SRAM write and response
  // ----------------------------------------

  // Out-of-range address never reaches the array
  always_comb begin
    o_wr_req.en   = wr_go_q & in_range;
    o_wr_req.idx  = aw_q.addr[OFFS_W +: `MEM_IDX_W];
    o_wr_req.word = w_q.data;
    o_wr_req.be   = w_q.strb;
  end

  assign o_bvalid = (state_q == RESP);

  always_comb begin
    o_b.id = aw_q.id;
    if (in_range) begin
      o_b.resp = OKAY;
    end else begin
      o_b.resp = DECERR;
    end
  end

endmodule

`default_nettype wire

/* axi_rd_ctrl.sv */
// AXI read channel controller
`default_nettype none

`include "axi_sram_params.svh"

module axi_rd_ctrl (
  input  logic                 i_aclk,
  input  logic                 i_arst_n,
  input  axi_pkg::axi_ar_t     i_ar,
  input  logic                 i_arvalid,
  output logic                 o_arready,
  output axi_pkg::axi_r_t      o_r,
  output logic                 o_rvalid,
  input  logic                 i_rready,
  output mem_pkg::mem_rd_req_t o_rd_req,
  input  mem_pkg::mem_word_t   i_rd_word
);
  import axi_pkg::*;
  import mem_pkg::*;

  // Byte offset bits, then index bits, then must-be-zero bits
  localparam int OFFS_W = $clog2(`AXI_STRB_W);
  localparam int HI_LSB = OFFS_W + `MEM_IDX_W;

  typedef enum logic {
    IDLE,
    DATA
  } rd_state_e;

  rd_state_e state_q;
  axi_id_t   id_q;
  axi_resp_e resp_q;
  logic      ar_fire;
  logic      r_fire;
  logic      ar_in_range;

  assign ar_fire     = i_arvalid & o_arready;
  assign r_fire      = i_rready & o_rvalid;
  assign ar_in_range = (i_ar.addr[`AXI_ADDR_W-1:HI_LSB] == '0);

  // ----------------------------------------
  // State machine
  // ----------------------------------------

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (ar_fire) state_q <= DATA;
        DATA:    if (r_fire) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // ID and decode result held for the whole response
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q <= i_ar.id;
      if (ar_in_range) begin
        resp_q <= OKAY;
      end else begin
        resp_q <= DECERR;
      end
    end
  end

  // SRAM read issued on the address transfer itself
  always_comb begin
    o_rd_req.en  = ar_fire & ar_in_range;
    o_rd_req.idx = i_ar.addr[OFFS_W +: `MEM_IDX_W];
  end

  // ----------------------------------------
  // Read data channel
  // ----------------------------------------

  assign o_arready = (state_q == IDLE);
  assign o_rvalid  = (state_q == DATA);

  always_comb begin
    o_r.id   = id_q;
    o_r.resp = resp_q;
    o_r.last = 1'b1;
    // Decode error returns zero rather than a stale word
    o_r.data = (resp_q == OKAY) ? i_rd_word : '0;
  end

endmodule

`default_nettype wire

/* sram_mem.sv */
// Byte-enable SRAM array
`default_nettype none

`include "axi_sram_params.svh"

module sram_mem (
  input  logic                 i_aclk,
  input  mem_pkg::mem_rd_req_t i_rd_req,
  input  mem_pkg::mem_wr_req_t i_wr_req,
  output mem_pkg::mem_word_t   o_rd_word
);
  import mem_pkg::*;

  localparam int DEPTH   = 1 << `MEM_IDX_W;
  localparam int NUM_BE  = $bits(mem_be_t);

  mem_word_t mem [DEPTH];

  // ----------------------------------------
  // Write port
  // ----------------------------------------

  // Lanes without an enable keep their old byte
  always_ff @(posedge i_aclk) begin
    if (i_wr_req.en) begin
      for (int b = 0; b < NUM_BE; b++) begin
        if (i_wr_req.be[b]) begin
          mem[i_wr_req.idx][8*b +: 8] <= i_wr_req.word[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------

  // Output register loads only on a read enable, so a pending
  // response keeps its word under back-pressure.
  // Same-edge write lands after this sample, read sees old data
  always_ff @(posedge i_aclk) begin
    if (i_rd_req.en) begin
      o_rd_word <= mem[i_rd_req.idx];
    end
  end

endmodule

`default_nettype wire

/* mem_pkg.sv */
// SRAM access types
`default_nettype none

`include "axi_sram_params.svh"

package mem_pkg;

  // Word index, byte offset already stripped
  typedef logic [`MEM_IDX_W-1:0]  mem_idx_t;
  typedef logic [`AXI_DATA_W-1:0] mem_word_t;
  typedef logic [`AXI_STRB_W-1:0] mem_be_t;

  // ----------------------------------------
  // Port requests
  // ----------------------------------------

  typedef struct packed {
    logic     en;
    mem_idx_t idx;
  } mem_rd_req_t;

  // One enable per byte lane
  typedef struct packed {
    logic      en;
    mem_idx_t  idx;
    mem_word_t word;
    mem_be_t   be;
  } mem_wr_req_t;

endpackage

`default_nettype wire

/* axi_pkg.sv */
// AXI channel types
`default_nettype none

`include "axi_sram_params.svh"

package axi_pkg;

  // ----------------------------------------
  // Field types
  // ----------------------------------------

  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0] axi_data_t;
  typedef logic [`AXI_ID_W-1:0]   axi_id_t;
  typedef logic [`AXI_STRB_W-1:0] axi_strb_t;

  // Only the codes this slave can return
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } axi_resp_e;

  // ----------------------------------------
  // Channel payloads
  // ----------------------------------------

  // Write address
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
  } axi_aw_t;

  // Write data, single beat so no last flag
  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  // Write response
  typedef struct packed {
    axi_id_t   id;
    axi_resp_e resp;
  } axi_b_t;

  // Read address
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
  } axi_ar_t;

  // Read data
  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_e resp;
    logic      last;
  } axi_r_t;

endpackage

`default_nettype wire

/* axi_sram_params.svh */
// AXI SRAM width parameters
`ifndef AXI_SRAM_PARAMS_SVH
`define AXI_SRAM_PARAMS_SVH

// ----------------------------------------
// AXI port widths
// ----------------------------------------

// Byte address
`define AXI_ADDR_W 32

// Data bus, one beat
`define AXI_DATA_W 64

// Transaction ID
`define AXI_ID_W 4

// One strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W / 8)

// ----------------------------------------
// Memory geometry
// ----------------------------------------

// Word index, 1024 words of 8 bytes
`define MEM_IDX_W 10

`endif
